// File: Makefile
TOP       ?= lcd_tb
FILELIST  ?= lcd_wb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/lcd_cmd_fifo.sv
`default_nettype none

module lcd_cmd_fifo
	import lcd_pkg::*;
(
	input  logic               clk,
	input  logic               arst_n,
	input  logic               push,
	input  logic [ENTRY_W-1:0] push_entry,
	input  logic               pop,
	output logic [ENTRY_W-1:0] pop_entry,
	output logic               full,
	output logic               empty
);

	logic [ENTRY_W-1:0]    mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_CNT_W-1:0] count;
	logic                  do_push;
	logic                  do_pop;

	function automatic logic [FIFO_PTR_W-1:0] ptr_next(input logic [FIFO_PTR_W-1:0] p);
		logic [FIFO_PTR_W-1:0] n;
		if (p == FIFO_PTR_W'(FIFO_DEPTH - 1)) begin
			n = '0;  // wrap
		end else begin
			n = p + 1'b1;
		end
		return n;
	endfunction

	assign do_push   = push && !full;
	assign do_pop    = pop && !empty;
	assign full      = (count == FIFO_CNT_W'(FIFO_DEPTH));
	assign empty     = (count == '0);
	assign pop_entry = mem[rd_ptr];  // head, valid while not empty

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_entry;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/lcd_ctrl.sv
`default_nettype none

module lcd_ctrl
	import lcd_pkg::*;
(
	input  logic               clk,
	input  logic               arst_n,
	input  logic [CFG_W-1:0]   cfg,
	input  logic               empty,
	input  logic [ENTRY_W-1:0] pop_entry,
	output logic               pop,
	output logic               busy,
	output logic               e,
	output logic               rs,
	output logic               rw,
	output logic [7:0]         lcd_data
);

	logic [1:0]       state;
	logic [CNT_W-1:0] cnt;
	logic [1:0]       step;       // init instruction index
	logic             in_wait;    // init phase, low while e is high
	logic [CFG_W-1:0] cfg_q;
	logic             powerup_done;
	wb_word_u         cfg_live_view;
	wb_word_u         cfg_view;
	wb_word_u         entry_view;

	// instruction table, bit layout as in the HD44780 datasheet
	function automatic logic [7:0] init_instr(input logic [1:0] idx, input wb_word_u c);
		logic [7:0] instr;
		case (idx)
			2'd0:    instr = {4'b0011, c.cfg.display_lines, c.cfg.font, 2'b00};  // 8-bit bus
			2'd1:    instr = {5'b00001, c.cfg.display_on, c.cfg.cursor, c.cfg.blink};
			2'd2:    instr = 8'h01;  // clear
			default: instr = {6'b000001, c.cfg.inc_dec, c.cfg.shift};
		endcase
		return instr;
	endfunction

	// last count of the wait that follows each init pulse
	function automatic logic [CNT_W-1:0] init_wait(input logic [1:0] idx);
		logic [CNT_W-1:0] last;
		case (idx)
			2'd0:    last = CNT_W'(T_FSET_WAIT_CYC - 1);
			2'd1:    last = CNT_W'(T_DISP_WAIT_CYC - 1);
			2'd2:    last = CNT_W'(T_CLEAR_WAIT_CYC - 1);
			default: last = CNT_W'(T_ENTRY_WAIT_CYC - 1);
		endcase
		return last;
	endfunction

	assign cfg_live_view = {{(WB_W-CFG_W){1'b0}}, cfg};
	assign cfg_view      = {{(WB_W-CFG_W){1'b0}}, cfg_q};
	assign entry_view    = {{(WB_W-ENTRY_W){1'b0}}, pop_entry};
	assign powerup_done  = (state == ST_POWERUP) && (cnt == CNT_W'(T_POWERUP_CYC - 1));
	assign pop           = (state == ST_IDLE) && !empty;  // take the head this cycle

	always_ff @(posedge clk) begin
		if (powerup_done) begin
			cfg_q <= cfg;  // held for the rest of init
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= ST_POWERUP;
			cnt      <= '0;
			step     <= '0;
			in_wait  <= 1'b0;
			busy     <= 1'b1;
			e        <= 1'b0;
			rs       <= 1'b0;
			rw       <= 1'b0;
			lcd_data <= '0;
		end else begin
			case (state)
				ST_POWERUP: begin
					if (powerup_done) begin
						cnt      <= '0;
						step     <= 2'd0;
						in_wait  <= 1'b0;
						e        <= 1'b1;  // function set pulse starts
						lcd_data <= init_instr(2'd0, cfg_live_view);
						state    <= ST_INIT;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				ST_INIT: begin
					if (!in_wait) begin
						if (cnt == CNT_W'(T_PULSE_CYC - 1)) begin
							cnt     <= '0;
							e       <= 1'b0;
							in_wait <= 1'b1;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end else if (cnt == init_wait(step)) begin
						cnt     <= '0;
						in_wait <= 1'b0;
						if (step == 2'd3) begin
							busy     <= 1'b0;  // panel ready
							lcd_data <= '0;
							state    <= ST_IDLE;
						end else begin
							step     <= step + 1'b1;
							e        <= 1'b1;
							lcd_data <= init_instr(step + 1'b1, cfg_view);
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				ST_IDLE: begin
					if (!empty) begin
						cnt      <= '0;
						busy     <= 1'b1;
						rs       <= entry_view.entry.rs;
						rw       <= entry_view.entry.rw;
						lcd_data <= entry_view.entry.data;
						state    <= ST_WRITE;
					end
				end
				ST_WRITE: begin
					// setup, then e high from 1 us up to 14 us
					if (cnt == CNT_W'(T_E_RISE_CYC - 1)) begin
						e <= 1'b1;
					end
					if (cnt == CNT_W'(T_E_FALL_CYC - 1)) begin
						e <= 1'b0;
					end
					if (cnt == CNT_W'(T_CYCLE_CYC - 1)) begin
						cnt      <= '0;
						busy     <= 1'b0;
						rs       <= 1'b0;
						rw       <= 1'b0;
						lcd_data <= '0;
						state    <= ST_IDLE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/lcd_pkg.sv
`default_nettype none

package lcd_pkg;

	localparam int CLK_PER_US = 4;  // scaled down for simulation

	localparam int T_POWERUP_US    = 500;
	localparam int T_FSET_WAIT_US  = 50;
	localparam int T_DISP_WAIT_US  = 50;
	localparam int T_CLEAR_WAIT_US = 200;  // clear is the slow one
	localparam int T_ENTRY_WAIT_US = 100;
	localparam int T_PULSE_US      = 10;
	localparam int T_CYCLE_US      = 50;
	localparam int T_E_RISE_US     = 1;
	localparam int T_E_FALL_US     = 14;

	localparam int T_POWERUP_CYC    = T_POWERUP_US * CLK_PER_US;
	localparam int T_FSET_WAIT_CYC  = T_FSET_WAIT_US * CLK_PER_US;
	localparam int T_DISP_WAIT_CYC  = T_DISP_WAIT_US * CLK_PER_US;
	localparam int T_CLEAR_WAIT_CYC = T_CLEAR_WAIT_US * CLK_PER_US;
	localparam int T_ENTRY_WAIT_CYC = T_ENTRY_WAIT_US * CLK_PER_US;
	localparam int T_PULSE_CYC      = T_PULSE_US * CLK_PER_US;
	localparam int T_CYCLE_CYC      = T_CYCLE_US * CLK_PER_US;
	localparam int T_E_RISE_CYC     = T_E_RISE_US * CLK_PER_US;
	localparam int T_E_FALL_CYC     = T_E_FALL_US * CLK_PER_US;

	localparam int CNT_W = $clog2(T_POWERUP_CYC);  // longest wait sets the width

	localparam int ENTRY_W    = 10;  // {rs, rw, data}
	localparam int CFG_W      = 7;
	localparam int WB_W       = 16;
	localparam int ADR_W      = 2;
	localparam int FIFO_DEPTH = 8;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

	localparam logic [ADR_W-1:0] ADR_CFG    = 2'd0;
	localparam logic [ADR_W-1:0] ADR_CMD    = 2'd1;
	localparam logic [ADR_W-1:0] ADR_STATUS = 2'd2;

	// two lines, 5x8 font, display on, increment
	localparam logic [CFG_W-1:0] CFG_RESET = 7'b1010010;

	localparam logic [1:0] ST_POWERUP = 2'd0;
	localparam logic [1:0] ST_INIT    = 2'd1;
	localparam logic [1:0] ST_IDLE    = 2'd2;
	localparam logic [1:0] ST_WRITE   = 2'd3;

	typedef union packed {
		struct packed {
			logic [WB_W-CFG_W-1:0] pad;
			logic display_lines;
			logic font;
			logic display_on;
			logic cursor;
			logic blink;
			logic inc_dec;
			logic shift;
		} cfg;
		struct packed {
			logic [WB_W-ENTRY_W-1:0] pad;
			logic rs;
			logic rw;
			logic [7:0] data;
		} entry;
	} wb_word_u;

endpackage

`default_nettype wire

// File: design/lcd_top.sv
`default_nettype none

module lcd_top
	import lcd_pkg::*;
(
	input  logic             clk,
	input  logic             arst_n,
	input  logic             cyc,
	input  logic             stb,
	input  logic             we,
	input  logic [ADR_W-1:0] adr,
	input  logic [WB_W-1:0]  dat_w,
	output logic [WB_W-1:0]  dat_r,
	output logic             ack,
	output logic             e,
	output logic             rs,
	output logic             rw,
	output logic [7:0]       lcd_data
);

	logic [CFG_W-1:0]   cfg;
	logic               push;
	logic [ENTRY_W-1:0] push_entry;
	logic               pop;
	logic [ENTRY_W-1:0] pop_entry;
	logic               full;
	logic               empty;
	logic               busy;

	lcd_wb_regs lcd_wb_regs_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.cyc        (cyc),
		.stb        (stb),
		.we         (we),
		.adr        (adr),
		.dat_w      (dat_w),
		.dat_r      (dat_r),
		.ack        (ack),
		.cfg        (cfg),
		.push       (push),
		.push_entry (push_entry),
		.full       (full),
		.busy       (busy),
		.empty      (empty)
	);

	lcd_cmd_fifo lcd_cmd_fifo_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.push       (push),
		.push_entry (push_entry),
		.pop        (pop),
		.pop_entry  (pop_entry),
		.full       (full),
		.empty      (empty)
	);

	lcd_ctrl lcd_ctrl_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.cfg       (cfg),
		.empty     (empty),
		.pop_entry (pop_entry),
		.pop       (pop),
		.busy      (busy),
		.e         (e),
		.rs        (rs),
		.rw        (rw),
		.lcd_data  (lcd_data)
	);

endmodule

`default_nettype wire

// File: design/lcd_wb_regs.sv
`default_nettype none

module lcd_wb_regs
	import lcd_pkg::*;
(
	input  logic               clk,
	input  logic               arst_n,
	input  logic               cyc,
	input  logic               stb,
	input  logic               we,
	input  logic [ADR_W-1:0]   adr,
	input  logic [WB_W-1:0]    dat_w,
	output logic [WB_W-1:0]    dat_r,
	output logic               ack,
	output logic [CFG_W-1:0]   cfg,
	output logic               push,
	output logic [ENTRY_W-1:0] push_entry,
	input  logic               full,
	input  logic               busy,
	input  logic               empty
);

	wb_word_u wr_word;
	logic     req;
	logic     cfg_wr;
	logic     cmd_wr;
	logic     stall;
	logic     take;

	assign wr_word = dat_w;
	assign req     = cyc && stb && !ack;  // no new decode during the ack cycle
	assign cfg_wr  = we && (adr == ADR_CFG);
	assign cmd_wr  = we && (adr == ADR_CMD);
	assign stall   = cmd_wr && full;  // hold the master off until a slot frees
	assign take    = req && !stall;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ack  <= 1'b0;
			push <= 1'b0;
		end else begin
			ack  <= take;  // one cycle, drops by itself
			push <= take && cmd_wr;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cfg <= CFG_RESET;
		end else if (take && cfg_wr) begin
			cfg <= {
				wr_word.cfg.display_lines,
				wr_word.cfg.font,
				wr_word.cfg.display_on,
				wr_word.cfg.cursor,
				wr_word.cfg.blink,
				wr_word.cfg.inc_dec,
				wr_word.cfg.shift
			};
		end
	end

	// entry leaves together with the push strobe
	always_ff @(posedge clk) begin
		if (take && cmd_wr) begin
			push_entry <= {wr_word.entry.rs, wr_word.entry.rw, wr_word.entry.data};
		end
	end

	always_ff @(posedge clk) begin
		if (take && !we) begin
			case (adr)
				ADR_STATUS: dat_r <= {{(WB_W-3){1'b0}}, empty, full, busy};
				ADR_CFG:    dat_r <= {{(WB_W-CFG_W){1'b0}}, cfg};
				default:    dat_r <= '0;  // unmapped reads as zero
			endcase
		end
	end

endmodule

`default_nettype wire

// File: lcd_wb.f
design/lcd_pkg.sv
design/lcd_cmd_fifo.sv
design/lcd_wb_regs.sv
design/lcd_ctrl.sv
design/lcd_top.sv
sim/tb_clk_gen.sv
sim/lcd_props.sv
sim/lcd_tb.sv

// File: sim/lcd_props.sv
`default_nettype none

module lcd_props (
	input logic       clk,
	input logic       arst_n,
	input logic       cyc,
	input logic       stb,
	input logic       ack,
	input logic       busy,
	input logic       e,
	input logic       rs,
	input logic       rw,
	input logic [7:0] lcd_data
);

	// panel latches on the falling edge of e, so the bus must not move while e is high
	a_pins_stable: assert property (@(posedge clk) disable iff (!arst_n)
		(e && $past(e)) |-> $stable({rs, rw, lcd_data}))
		else $error("rs, rw or lcd_data changed while e was high");

	a_ack_in_cycle: assert property (@(posedge clk) disable iff (!arst_n)
		ack |-> (cyc && stb))
		else $error("ack high outside a Wishbone cycle");

	a_e_needs_busy: assert property (@(posedge clk) disable iff (!arst_n)
		e |-> busy)
		else $error("e high while the sequencer reports idle");

endmodule

bind lcd_top lcd_props lcd_props_i (
	.clk      (clk),
	.arst_n   (arst_n),
	.cyc      (cyc),
	.stb      (stb),
	.ack      (ack),
	.busy     (busy),
	.e        (e),
	.rs       (rs),
	.rw       (rw),
	.lcd_data (lcd_data)
);

`default_nettype wire

// File: sim/lcd_tb.sv
`default_nettype none

module lcd_tb
	import lcd_pkg::*;
();

	localparam logic [31:0] SEED = 32'ha5ba;
	localparam int N_RANDOM    = 5;
	localparam int N_BURST     = FIFO_DEPTH + 3;
	localparam int ACK_TIMEOUT = 1000;  // longer than one write cycle of back-pressure

	logic               clk;
	logic               arst_n;
	logic               cyc;
	logic               stb;
	logic               we;
	logic [ADR_W-1:0]   adr;
	logic [WB_W-1:0]    dat_w;
	logic [WB_W-1:0]    dat_r;
	logic               ack;
	logic               e;
	logic               rs;
	logic               rw;
	logic [7:0]         lcd_data;

	logic [CFG_W-1:0]   cfg_written;
	logic [ENTRY_W-1:0] cmd_list[$];
	logic [ENTRY_W-1:0] seen_q[$];   // {rs, rw, data} at each falling e
	int                 n_compared = 0;
	int                 cyc_count = 0;
	int                 first_e_cycle = 0;
	logic               e_seen = 1'b0;
	logic               e_prev = 1'b0;

	tb_clk_gen clk_gen_i (
		.clk    (clk),
		.arst_n (arst_n)
	);

	lcd_top lcd_top_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.cyc      (cyc),
		.stb      (stb),
		.we       (we),
		.adr      (adr),
		.dat_w    (dat_w),
		.dat_r    (dat_r),
		.ack      (ack),
		.e        (e),
		.rs       (rs),
		.rw       (rw),
		.lcd_data (lcd_data)
	);

	task automatic stop_failed();
		$display("Testbench failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_equal(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("ERROR %s expected %0h actual %0h", name, expected, actual);
			stop_failed();
		end
	endtask

	// HD44780 instruction encodings with cfg bits N F D C B I/D S from bit 6 down
	function automatic logic [ENTRY_W-1:0] ref_entry(input int n);
		logic [7:0] instr;
		case (n)
			0:       instr = {3'b001, 1'b1, cfg_written[6], cfg_written[5], 2'b00};
			1:       instr = {5'b00001, cfg_written[4], cfg_written[3], cfg_written[2]};
			2:       instr = 8'h01;
			3:       instr = {6'b000001, cfg_written[1], cfg_written[0]};
			default: instr = 8'h00;
		endcase
		if (n >= 4) begin
			return cmd_list[n-4];
		end else begin
			return {2'b00, instr};  // init runs with rs = rw = 0
		end
	endfunction

	task automatic bus_transfer(input logic wr, input logic [ADR_W-1:0] a,
			input logic [WB_W-1:0] wdata, output logic [WB_W-1:0] rdata);
		int waited;
		waited = 0;
		@(posedge clk);
		cyc   <= 1'b1;
		stb   <= 1'b1;
		we    <= wr;
		adr   <= a;
		dat_w <= wdata;
		@(negedge clk);
		while (!ack) begin
			waited++;
			if (waited > ACK_TIMEOUT) begin
				$display("no ack from the Wishbone slave at address %0d", a);
				stop_failed();
			end
			@(negedge clk);
		end
		rdata = dat_r;
		@(posedge clk);
		cyc <= 1'b0;
		stb <= 1'b0;
		we  <= 1'b0;
	endtask

	task automatic send_entry();
		logic [31:0]     r;
		logic [WB_W-1:0] rd;
		r = $urandom();
		cmd_list.push_back(r[ENTRY_W-1:0]);
		bus_transfer(1'b1, ADR_CMD, WB_W'(r[ENTRY_W-1:0]), rd);
	endtask

	task automatic wait_compared(input int total, input int limit, input string what);
		int waited;
		waited = 0;
		while (n_compared < total) begin
			@(negedge clk);
			waited++;
			if (waited > limit) begin
				$display("timed out waiting for %s, %0d of %0d transfers seen",
					what, n_compared, total);
				stop_failed();
			end
		end
	endtask

	always @(posedge clk) begin
		if (arst_n) begin
			cyc_count <= cyc_count + 1;
		end
	end

	// pin monitor sampled away from the driving edge
	always @(negedge clk) begin
		if (arst_n) begin
			if (e && !e_seen) begin
				e_seen        = 1'b1;
				first_e_cycle = cyc_count;
			end
			if (e_prev && !e) begin
				seen_q.push_back({rs, rw, lcd_data});
			end
			e_prev = e;
		end
	end

	always @(posedge clk) begin : compare_proc
		logic [ENTRY_W-1:0] got;
		if (seen_q.size() > 0) begin
			got = seen_q.pop_front();
			if (n_compared >= 4 + cmd_list.size()) begin
				$display("panel transfer %0d was never requested", n_compared);
				stop_failed();
			end
			check_equal($sformatf("transfer_%0d", n_compared),
				32'(ref_entry(n_compared)), 32'(got));
			n_compared++;
		end
	end

	initial begin
		logic [31:0]     r;
		logic [WB_W-1:0] rd;
		int              waited;
		logic            full_seen;
		cyc   = 1'b0;
		stb   = 1'b0;
		we    = 1'b0;
		adr   = '0;
		dat_w = '0;
		r = $urandom(SEED);
		waited = 0;
		while (!arst_n) begin
			@(negedge clk);
			waited++;
			if (waited > 10) begin
				$display("reset was never released");
				stop_failed();
			end
		end

		bus_transfer(1'b0, ADR_STATUS, '0, rd);
		check_equal("busy_after_reset", 32'd1, 32'(rd[0]));

		r = $urandom();
		cfg_written = r[CFG_W-1:0];
		bus_transfer(1'b1, ADR_CFG, WB_W'(cfg_written), rd);  // still in power-up

		for (int i = 0; i < N_RANDOM; i++) begin
			send_entry();
		end
		wait_compared(4 + N_RANDOM, 20000, "init and random entries");
		check_equal("no_e_before_powerup", 32'd1, 32'(first_e_cycle >= T_POWERUP_CYC));

		// more than the FIFO holds so the last writes stall on full
		for (int i = 0; i < N_BURST; i++) begin
			send_entry();
		end
		full_seen = 1'b0;
		waited = 0;
		while (!full_seen) begin
			bus_transfer(1'b0, ADR_STATUS, '0, rd);
			full_seen = rd[1];
			waited++;
			if (waited > 50) begin
				$display("status never showed the FIFO full during the burst");
				stop_failed();
			end
		end
		wait_compared(4 + N_RANDOM + N_BURST, 30000, "burst entries");

		rd = '1;
		waited = 0;
		while (rd[0]) begin
			bus_transfer(1'b0, ADR_STATUS, '0, rd);
			waited++;
			if (waited > 200) begin
				$display("sequencer stayed busy after the last transfer");
				stop_failed();
			end
		end
		check_equal("status_drained", 32'h4, 32'(rd[2:0]));
		bus_transfer(1'b0, ADR_CFG, '0, rd);
		check_equal("cfg_readback", 32'(cfg_written), 32'(rd));

		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;  // period 20
	end

	initial begin
		arst_n = 1'b0;
		repeat (3) @(posedge clk);
		arst_n <= 1'b1;  // released on an edge, flops still see reset there
	end

endmodule

`default_nettype wire
